// ==== design/fp_pkg.sv ====
// IEEE single-precision format definitions
// Field widths, exponent bias and a word type that can be
// read either as raw bits or as sign, exponent and fraction
package fp_pkg;

  // Field widths of a single word
  localparam int WORD_W = 32;
  localparam int EXP_W  = 8;
  localparam int FRAC_W = 23;

  // Exponent bias, one bit wider than the field
  // so an unbiased exponent fits a signed register of the same width
  localparam logic [EXP_W:0] EXP_BIAS = 9'd127;

  // Decoded view, sign in the top bit
  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exponent;
    logic [FRAC_W-1:0] fraction;
  } single_fields_t;

  // One float word, two readings of the same bits
  // Raw view for moving words, field view for decoding
  typedef union packed {
    logic [WORD_W-1:0] raw;
    single_fields_t    fields;
  } single_word_u;

endpackage

// ==== design/farm_pkg.sv ====
// Converter farm definitions
// Lane count, lane pointer width, integer result constants
// and the result word a lane offers to the collector
package farm_pkg;

  // Number of converter lanes side by side
  localparam int NUM_LANES  = 4;

  // Pointer width for issue and drain rotation
  localparam int LANE_IDX_W = 2;

  // Width of the integer result
  localparam int INT_W      = 32;

  // Overflow and out-of-range result
  localparam logic [INT_W-1:0] INT_MIN_WORD = 32'h8000_0000;

  // Lane output, ready flag on top of the value
  typedef struct packed {
    logic             ready;
    logic [INT_W-1:0] value;
  } lane_result_t;

endpackage

// ==== design/f2i_lane.sv ====
// Iterative float-to-integer converter lane
// Takes one single word, unpacks it, handles zero and range
// specials, then shifts the mantissa one bit per cycle until the
// exponent reaches the integer top bit; truncates toward zero
`timescale 1ns/1ps

module f2i_lane (
  input  logic                   clk,
  input  logic                   rst,
  input  fp_pkg::single_word_u   single_val,
  input  logic                   single_cont,
  output logic                   single_ready,
  output farm_pkg::lane_result_t result,
  input  logic                   int_cont
);

  import fp_pkg::*;
  import farm_pkg::*;

  // Conversion sequence
  typedef enum logic [2:0] {
    ST_GET_IN,
    ST_UNPACK,
    ST_SPECIAL,
    ST_CONVERT,
    ST_PUT_OUT
  } state_t;

  state_t              state_q;
  single_word_u        a_q;
  logic [INT_W-1:0]    man_q;
  logic signed [EXP_W:0] exp_q;
  logic                sign_q;
  logic                in_ready_q;
  lane_result_t        result_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q        <= ST_GET_IN;
      in_ready_q     <= 1'b0;
      result_q.ready <= 1'b0;
    end
    else
    begin
      case (state_q)
        // Wait for a float from the dispatcher
        ST_GET_IN:
        begin
          if (in_ready_q && single_cont)
          begin
            a_q        <= single_val;
            in_ready_q <= 1'b0;
            state_q    <= ST_UNPACK;
          end
          else
          begin
            in_ready_q <= 1'b1;
          end
        end

        // Hidden one on top, fraction below it, zero fill
        ST_UNPACK:
        begin
          man_q   <= {1'b1, a_q.fields.fraction, {(INT_W - FRAC_W - 1){1'b0}}};
          exp_q   <= signed'({1'b0, a_q.fields.exponent} - EXP_BIAS);
          sign_q  <= a_q.fields.sign;
          state_q <= ST_SPECIAL;
        end

        ST_SPECIAL:
        begin
          // Zero and denormals
          if (a_q.fields.exponent == '0)
          begin
            result_q.value <= '0;
            result_q.ready <= 1'b1;
            state_q        <= ST_PUT_OUT;
          end
          // Too large, infinities and NaNs too
          else if (exp_q > INT_W - 1)
          begin
            result_q.value <= INT_MIN_WORD;
            result_q.ready <= 1'b1;
            state_q        <= ST_PUT_OUT;
          end
          else
          begin
            state_q <= ST_CONVERT;
          end
        end

        // One right shift per cycle until bit 31 weighs 2^31
        ST_CONVERT:
        begin
          if (exp_q < INT_W - 1 && man_q != '0)
          begin
            exp_q <= exp_q + 9'sd1;
            man_q <= man_q >> 1;
          end
          else
          begin
            // Top bit still set means magnitude of 2^31 or more
            if (man_q[INT_W-1])
              result_q.value <= INT_MIN_WORD;
            else
              result_q.value <= sign_q ? -man_q : man_q;
            result_q.ready <= 1'b1;
            state_q        <= ST_PUT_OUT;
          end
        end

        // Hold result until the collector takes it
        ST_PUT_OUT:
        begin
          if (result_q.ready && int_cont)
          begin
            result_q.ready <= 1'b0;
            in_ready_q     <= 1'b1;
            state_q        <= ST_GET_IN;
          end
        end

        default:
        begin
          state_q <= ST_GET_IN;
        end
      endcase
    end
  end

  assign single_ready = in_ready_q;
  assign result       = result_q;

endmodule

// ==== design/f2i_dispatch.sv ====
// Round-robin float dispatcher
// One-word input buffer; the buffered float goes to the lane
// under the issue pointer, which then moves to the next lane
`timescale 1ns/1ps

module f2i_dispatch (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [fp_pkg::WORD_W-1:0]      single_val,
  input  logic                           single_cont,
  output logic                           single_ready,
  output fp_pkg::single_word_u           lane_val,
  output logic [farm_pkg::NUM_LANES-1:0] lane_cont,
  input  logic [farm_pkg::NUM_LANES-1:0] lane_ready
);

  import fp_pkg::*;
  import farm_pkg::*;

  single_word_u          buf_q;
  logic                  full_q;
  logic                  full_d;
  logic                  ready_q;
  logic [LANE_IDX_W-1:0] ptr_q;
  logic                  take;
  logic                  issue;

  always_comb
  begin
    // Word in from the source
    take  = ready_q && single_cont;
    // Word out to the pointed lane
    issue = full_q && lane_ready[ptr_q];

    if (take)
      full_d = 1'b1;
    else if (issue)
      full_d = 1'b0;
    else
      full_d = full_q;

    // Offer only to the pointed lane
    lane_cont = '0;
    if (full_q)
      lane_cont[ptr_q] = 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      full_q  <= 1'b0;
      ready_q <= 1'b0;
      ptr_q   <= '0;
    end
    else
    begin
      full_q  <= full_d;
      // Ready tracks an empty buffer
      ready_q <= !full_d;
      if (issue)
        ptr_q <= (ptr_q == LANE_IDX_W'(NUM_LANES - 1)) ? '0 : ptr_q + 1'b1;
    end
  end

  // Buffered float
  always_ff @(posedge clk)
  begin
    if (take)
      buf_q.raw <= single_val;
  end

  assign single_ready = ready_q;
  assign lane_val     = buf_q;

endmodule

// ==== design/f2i_collect.sv ====
// In-order result collector
// Drains lane results with the same rotation the dispatcher
// used, so integers leave in the order the floats arrived;
// one-word output buffer toward the sink
`timescale 1ns/1ps

module f2i_collect (
  input  logic                           clk,
  input  logic                           rst,
  input  farm_pkg::lane_result_t         results [farm_pkg::NUM_LANES],
  output logic [farm_pkg::NUM_LANES-1:0] result_cont,
  output logic [farm_pkg::INT_W-1:0]     int_val,
  output logic                           int_ready,
  input  logic                           int_cont
);

  import farm_pkg::*;

  lane_result_t          sel;
  logic [LANE_IDX_W-1:0] ptr_q;
  logic                  open_q;
  logic                  full_q;
  logic                  full_d;
  logic [INT_W-1:0]      val_q;
  logic                  take;
  logic                  give;

  always_comb
  begin
    // Lane under the drain pointer
    sel  = results[ptr_q];
    // From that lane into the buffer
    take = open_q && sel.ready;
    // Out to the sink
    give = full_q && int_cont;

    if (take)
      full_d = 1'b1;
    else if (give)
      full_d = 1'b0;
    else
      full_d = full_q;

    // Accept only from the pointed lane
    result_cont = '0;
    if (open_q)
      result_cont[ptr_q] = 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      full_q <= 1'b0;
      open_q <= 1'b0;
      ptr_q  <= '0;
      val_q  <= '0;
    end
    else
    begin
      full_q <= full_d;
      // Open for a lane result while the buffer is empty
      open_q <= !full_d;
      if (take)
      begin
        val_q <= sel.value;
        ptr_q <= (ptr_q == LANE_IDX_W'(NUM_LANES - 1)) ? '0 : ptr_q + 1'b1;
      end
    end
  end

  // Value holds while waiting on the sink
  assign int_val   = val_q;
  assign int_ready = full_q;

endmodule

// ==== design/f2i_farm.sv ====
// Float-to-integer converter farm
// Dispatcher feeds NUM_LANES iterative converters in rotation;
// the collector drains them in the same rotation
`timescale 1ns/1ps

module f2i_farm (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [fp_pkg::WORD_W-1:0]    single_val,
  input  logic                         single_cont,
  output logic                         single_ready,
  output logic [farm_pkg::INT_W-1:0]   int_val,
  output logic                         int_ready,
  input  logic                         int_cont
);

  import fp_pkg::*;
  import farm_pkg::*;

  // Dispatcher to lanes
  single_word_u         lane_val;
  logic [NUM_LANES-1:0] lane_cont;
  logic [NUM_LANES-1:0] lane_ready;

  // Lanes to collector
  lane_result_t         results [NUM_LANES];
  logic [NUM_LANES-1:0] result_cont;

  f2i_dispatch u_dispatch (
    .clk          (clk),
    .rst          (rst),
    .single_val   (single_val),
    .single_cont  (single_cont),
    .single_ready (single_ready),
    .lane_val     (lane_val),
    .lane_cont    (lane_cont),
    .lane_ready   (lane_ready)
  );

  // Identical converter lanes, shared input word
  for (genvar i = 0; i < NUM_LANES; i++)
  begin : g_lane
    f2i_lane u_lane (
      .clk          (clk),
      .rst          (rst),
      .single_val   (lane_val),
      .single_cont  (lane_cont[i]),
      .single_ready (lane_ready[i]),
      .result       (results[i]),
      .int_cont     (result_cont[i])
    );
  end

  f2i_collect u_collect (
    .clk         (clk),
    .rst         (rst),
    .results     (results),
    .result_cont (result_cont),
    .int_val     (int_val),
    .int_ready   (int_ready),
    .int_cont    (int_cont)
  );

endmodule

// ==== bench/f2i_model.svh ====
// Reference model for the converter farm testbench
// Float-to-integer conversion by the truncation rules, computed
// with a wide shift, and the LCG used for random stimulus

// Signed 32-bit result of one single word, truncated toward zero
function automatic logic [31:0] model_f2i(input logic [31:0] word);
  single_word_u u;
  int           unbiased;
  logic [63:0]  mag;
  u.raw = word;
  // Zero and denormals
  if (u.fields.exponent == 8'd0)
    return 32'd0;
  unbiased = int'(u.fields.exponent) - int'(EXP_BIAS);
  // Out of range, infinities and NaNs
  if (unbiased > 31)
    return INT_MIN_WORD;
  // Hidden one plus fraction, binary point below bit 23
  mag = {40'd0, 1'b1, u.fields.fraction};
  if (unbiased >= 23)
    mag = mag << (unbiased - 23);
  else
    mag = mag >> (23 - unbiased);
  // Magnitude of 2^31 or more does not fit
  if (mag >= 64'h8000_0000)
    return INT_MIN_WORD;
  return u.fields.sign ? -mag[31:0] : mag[31:0];
endfunction

// Next state of a 32-bit linear congruential generator
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// ==== bench/tb_f2i_farm.sv ====
// Testbench for the float-to-integer converter farm
// Directed specials and ordinary values, an LCG random stream, then
// a stalled sink; results checked in arrival order against a model
`timescale 1ns/1ps

module tb_f2i_farm;

  import fp_pkg::*;
  import farm_pkg::*;

  `include "f2i_model.svh"

  localparam int N_DIRECTED     = 22;
  localparam int N_RANDOM       = 400;
  localparam int N_STALLED      = 150;
  localparam int NUM_ITEMS      = N_DIRECTED + N_RANDOM + N_STALLED;
  localparam int TIMEOUT_CYCLES = NUM_ITEMS * 40 + 1000;
  localparam logic [31:0] SEED  = 32'd34055;

  // Signed zeros, denormals, infinities, NaNs, range edges, then ordinary values
  localparam logic [31:0] DIRECTED_WORDS [N_DIRECTED] = '{
    32'h0000_0000, 32'h8000_0000, 32'h0000_0001, 32'h807F_FFFF,
    32'h0080_0000, 32'h7F80_0000, 32'hFF80_0000, 32'h7FC0_0000,
    32'hFFFF_FFFF, 32'h4F80_0000, 32'h4F00_0000, 32'hCF00_0000,
    32'h4F7F_FFFF, 32'h3F80_0000, 32'h3F40_0000, 32'hC020_0000,
    32'h47F1_2073, 32'h4EFF_FFFF, 32'hCEFF_FFFF, 32'h3F7F_FFFF,
    32'hBF7F_FFFF, 32'hC2F6_E979
  };

  logic        clk;
  logic        rst;
  logic [31:0] single_val;
  logic        single_cont;
  logic        single_ready;
  logic [31:0] int_val;
  logic        int_ready;
  logic        int_cont;

  // Scoreboard and counters
  logic [31:0] expected_q [$];
  logic [31:0] expected_val;
  int          in_count;
  int          out_count;
  int          mismatch_count;
  int          other_count;
  int          cycle_count;

  // Held output while the sink stalls
  logic        hold_pending;
  logic [31:0] held_val;

  // Random sources and sink mode
  logic [31:0] rand_state;
  logic [31:0] sink_state;
  logic        stall_mode;
  int          stretch_left;

  f2i_farm dut (
    .clk          (clk),
    .rst          (rst),
    .single_val   (single_val),
    .single_cont  (single_cont),
    .single_ready (single_ready),
    .int_val      (int_val),
    .int_ready    (int_ready),
    .int_cont     (int_cont)
  );

  always #5 clk = ~clk;

  task automatic print_summary;
    $display("Summary: %0d results checked, %0d mismatches, %0d other errors",
             out_count, mismatch_count, other_count);
  endtask

  // Offer one word once the farm is ready, hold it over one edge
  task automatic send_word(input logic [31:0] word);
    while (!single_ready)
      @(negedge clk);
    single_val  = word;
    single_cont = 1'b1;
    @(negedge clk);
    single_cont = 1'b0;
  endtask

  // Exponent field 120..163, so most words land in range
  task automatic send_random_word;
    logic [31:0]  frac_bits;
    logic [31:0]  sel_bits;
    single_word_u word;
    rand_state           = lcg_next(rand_state);
    frac_bits            = rand_state;
    rand_state           = lcg_next(rand_state);
    sel_bits             = rand_state;
    word.fields.sign     = sel_bits[31];
    word.fields.exponent = 8'd120 + 8'(sel_bits[23:16] % 8'd44);
    word.fields.fraction = frac_bits[30:8];
    send_word(word.raw);
  endtask

  task automatic wait_drained;
    while (out_count < in_count)
      @(negedge clk);
  endtask

  // Sink readiness, always high or random stretches
  always @(negedge clk)
  begin
    if (!stall_mode)
      int_cont = 1'b1;
    else if (stretch_left > 0)
      stretch_left--;
    else
    begin
      sink_state = lcg_next(sink_state);
      int_cont   = sink_state[28];
      // Low stretches long, high ones short
      stretch_left = int_cont ? int'(sink_state[18:16]) : 8 + int'(sink_state[21:16]);
    end
  end

  // Transfers seen on the rising edge, pre-edge values
  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (single_ready && single_cont)
      begin
        expected_q.push_back(model_f2i(single_val));
        in_count++;
      end
      if (int_ready && int_cont)
      begin
        if (expected_q.size() == 0)
        begin
          other_count++;
          $display("Error at %0t: result delivered with no input pending", $time);
        end
        else
        begin
          expected_val = expected_q.pop_front();
          assert (int_val === expected_val)
          else
          begin
            mismatch_count++;
            $display("Mismatch at %0t: int_val expected %08h got %08h",
                     $time, expected_val, int_val);
          end
          out_count++;
        end
      end
      // Stalled output must not move
      if (hold_pending)
      begin
        assert (int_ready)
        else
        begin
          other_count++;
          $display("Error at %0t: int_ready dropped before the result was taken", $time);
        end
        assert (int_val === held_val)
        else
        begin
          mismatch_count++;
          $display("Mismatch at %0t: int_val expected %08h got %08h",
                   $time, held_val, int_val);
        end
      end
      hold_pending = int_ready && !int_cont;
      held_val     = int_val;
      // Input buffer, lanes and output buffer
      assert (in_count - out_count <= NUM_LANES + 2)
      else
      begin
        other_count++;
        $display("Error at %0t: %0d words in flight, more than the farm can hold",
                 $time, in_count - out_count);
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      other_count++;
      $display("Error: run stopped after %0d cycles without finishing", cycle_count);
      print_summary();
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial
  begin
    clk            = 1'b0;
    rst            = 1'b1;
    single_val     = '0;
    single_cont    = 1'b0;
    int_cont       = 1'b0;
    in_count       = 0;
    out_count      = 0;
    mismatch_count = 0;
    other_count    = 0;
    cycle_count    = 0;
    hold_pending   = 1'b0;
    held_val       = '0;
    rand_state     = SEED;
    sink_state     = SEED;
    stall_mode     = 1'b0;
    stretch_left   = 0;

    // Both ready outputs low under reset
    repeat (2)
    begin
      @(negedge clk);
      assert (!single_ready && !int_ready)
      else
      begin
        other_count++;
        $display("Error at %0t: a ready output is high during reset", $time);
      end
    end
    rst = 1'b0;
    @(negedge clk);
    assert (single_ready)
    else
    begin
      other_count++;
      $display("Error at %0t: single_ready low in the first cycle after reset", $time);
    end

    for (int i = 0; i < N_DIRECTED; i++)
      send_word(DIRECTED_WORDS[i]);
    for (int i = 0; i < N_RANDOM; i++)
      send_random_word();
    wait_drained();

    // Mode change away from the sink's edge
    @(posedge clk);
    stall_mode = 1'b1;
    // Back to the driving edge
    @(negedge clk);
    for (int i = 0; i < N_STALLED; i++)
      send_random_word();
    wait_drained();
    // Room for any extra result to appear
    repeat (100) @(negedge clk);
    assert (expected_q.size() == 0 && out_count == NUM_ITEMS)
    else
    begin
      other_count++;
      $display("Error: %0d of %0d results delivered, %0d still pending",
               out_count, NUM_ITEMS, expected_q.size());
    end

    print_summary();
    if (mismatch_count == 0 && other_count == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== tb.f ====
design/fp_pkg.sv
design/farm_pkg.sv
design/f2i_lane.sv
design/f2i_dispatch.sv
design/f2i_collect.sv
design/f2i_farm.sv
+incdir+bench
bench/tb_f2i_farm.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_f2i_farm
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL TESTS PASSED

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(SIM): $(FILELIST) $(wildcard design/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
